// ==== filelist.f ====
hdl/led_panel_pkg.sv
hdl/command_parser.sv
hdl/display_config.sv
hdl/frame_memory.sv
hdl/matrix_scan.sv
hdl/pixel_fetch.sv
hdl/led_panel_top.sv
dv/led_panel_tb.sv

// ==== dv/led_panel_tb.sv ====
`timescale 1ns/10ps

module led_panel_tb;

    localparam int TIMEOUT_CYCLES = 4000;  // about 12 frames of scan plus the write traffic
    localparam int FRAME_LATCHES  = led_panel_pkg::HALF_HEIGHT * led_panel_pkg::PLANES;
    localparam int HALF_OFFSET    = led_panel_pkg::HALF_HEIGHT * led_panel_pkg::PANEL_WIDTH;

    logic                       clk_in;
    logic                       reset;
    logic [7:0]                 in_data;
    logic                       in_valid;
    logic                       in_ready;
    led_panel_pkg::rgb_t        rgb_top;
    led_panel_pkg::rgb_t        rgb_bottom;
    logic                       clk_pixel;
    logic                       row_latch;
    logic                       output_enable;
    led_panel_pkg::row_t        row_address;

    led_panel_pkg::pixel_t      shadow_fb [led_panel_pkg::PANEL_WIDTH *
                                           led_panel_pkg::PANEL_HEIGHT];
    led_panel_pkg::rgb_t        shadow_rgb   = '1;
    led_panel_pkg::plane_mask_t shadow_plane = '1;
    led_panel_pkg::rgb_t        top_cols    [led_panel_pkg::PANEL_WIDTH];
    led_panel_pkg::rgb_t        bottom_cols [led_panel_pkg::PANEL_WIDTH];

    logic [15:0] lfsr_state;
    logic        check_en     = 1'b0;  // compare rows only while the shadow is current
    logic        oe_seen      = 1'b0;  // an oe run ended since the last latch
    int          errors       = 0;
    int          rows_checked = 0;
    int          pix_count    = 0;
    int          latch_count  = 0;
    int          last_plane   = 0;
    int          oe_run       = 0;
    int          cycle_count  = 0;

    led_panel_top DUT (
        .clk_in(clk_in), .reset(reset),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .rgb_top(rgb_top), .rgb_bottom(rgb_bottom), .clk_pixel(clk_pixel),
        .row_latch(row_latch), .output_enable(output_enable), .row_address(row_address)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [7:0] random_bits(int n);
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[6:0], fb};
        end
        return v;
    endfunction

    // channel c shows pixel bit 2c+plane, gated by both enables
    function automatic led_panel_pkg::rgb_t expected_rgb(led_panel_pkg::pixel_t pix, int plane,
                                                         led_panel_pkg::rgb_t rgb_en,
                                                         led_panel_pkg::plane_mask_t plane_en);
        led_panel_pkg::rgb_t r;
        for (int c = 0; c < 3; c++) begin
            r[c] = pix[2 * c + plane] & rgb_en[c] & plane_en[plane];
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk_in);
        #5;
    endtask

    task automatic send_byte(logic [7:0] b);
        logic taken;
        in_data  = b;
        in_valid = 1'b1;
        do begin
            taken = in_ready;  // flop output, steady until the edge
            next_cycle();
        end while (!taken);
        in_valid = 1'b0;
        repeat (random_bits(1)) next_cycle();  // random idle gap
    endtask

    task automatic write_pixel(int addr, led_panel_pkg::pixel_t pix);
        send_byte(led_panel_pkg::OP_PIXEL);
        send_byte(8'(addr));
        send_byte(8'(pix));
        shadow_fb[addr] = pix;
    endtask

    task automatic write_rgb_enable(led_panel_pkg::rgb_t value);
        send_byte(led_panel_pkg::OP_RGB_ENABLE);
        send_byte(8'(value));
        shadow_rgb = value;
    endtask

    task automatic write_plane_enable(led_panel_pkg::plane_mask_t value);
        send_byte(led_panel_pkg::OP_PLANE_ENABLE);
        send_byte(8'(value));
        shadow_plane = value;
    endtask

    task automatic wait_frame_end();
        int target;
        target = (latch_count / FRAME_LATCHES + 1) * FRAME_LATCHES;
        while (latch_count < target) next_cycle();
    endtask

    // start at a frame boundary so every fetched row postdates the last write
    task automatic check_frames(int n);
        wait_frame_end();
        check_en = 1'b1;
        repeat (n) wait_frame_end();
        check_en = 1'b0;
    endtask

    task automatic check_quiet_outputs(logic ready_exp);
        if (clk_pixel !== 1'b0 || row_latch !== 1'b0 || output_enable !== 1'b0) begin
            errors++;
            $display("panel strobes are not low around reset");
        end
        if (in_ready !== ready_exp) begin
            errors++;
            $display("[FAIL] in_ready: expected 0x%h, got 0x%h", ready_exp, in_ready);
        end
    endtask

    task automatic compare_row();
        int row;
        int plane;
        int addr;
        led_panel_pkg::rgb_t want_top;
        led_panel_pkg::rgb_t want_bottom;
        row        = (latch_count / led_panel_pkg::PLANES) % led_panel_pkg::HALF_HEIGHT;
        plane      = latch_count % led_panel_pkg::PLANES;
        last_plane = plane;
        if (row_address !== led_panel_pkg::row_t'(row)) begin
            errors++;
            $display("[FAIL] row_address latch %0d: expected 0x%h, got 0x%h",
                     latch_count, led_panel_pkg::row_t'(row), row_address);
        end
        if (pix_count != led_panel_pkg::PANEL_WIDTH) begin
            errors++;
            $display("row %0d plane %0d was latched after %0d pixel clocks instead of 16",
                     row, plane, pix_count);
        end else if (check_en) begin
            rows_checked++;
            for (int col = 0; col < led_panel_pkg::PANEL_WIDTH; col++) begin
                addr        = row * led_panel_pkg::PANEL_WIDTH + col;
                want_top    = expected_rgb(shadow_fb[addr], plane, shadow_rgb, shadow_plane);
                want_bottom = expected_rgb(shadow_fb[addr + HALF_OFFSET], plane,
                                           shadow_rgb, shadow_plane);
                if (top_cols[col] !== want_top) begin
                    errors++;
                    $display("[FAIL] rgb_top col %0d row %0d plane %0d: expected 0x%h, got 0x%h",
                             col, row, plane, want_top, top_cols[col]);
                end
                if (bottom_cols[col] !== want_bottom) begin
                    errors++;
                    $display("[FAIL] rgb_bottom col %0d row %0d plane %0d: expected 0x%h, got 0x%h",
                             col, row, plane, want_bottom, bottom_cols[col]);
                end
            end
        end
    endtask

    // sampled mid-cycle, away from both edges
    always @(negedge clk_in) begin
        if (!reset) begin
            if (clk_pixel === 1'b1) begin
                if (pix_count < led_panel_pkg::PANEL_WIDTH) begin
                    top_cols[pix_count]    = rgb_top;
                    bottom_cols[pix_count] = rgb_bottom;
                end
                pix_count++;
            end
            if (row_latch === 1'b1) begin
                if (latch_count > 0 && !oe_seen) begin
                    errors++;
                    $display("no output_enable pulse followed latch %0d", latch_count - 1);
                end
                oe_seen = 1'b0;
                compare_row();
                pix_count = 0;
                latch_count++;
            end
            if (output_enable === 1'b1) begin
                oe_run++;
            end else if (oe_run != 0) begin
                if (oe_run != (led_panel_pkg::DISPLAY_UNIT << last_plane)) begin
                    errors++;
                    $display("[FAIL] output_enable run, plane %0d: expected 0x%h, got 0x%h",
                             last_plane, led_panel_pkg::DISPLAY_UNIT << last_plane, oe_run);
                end
                oe_run  = 0;
                oe_seen = 1'b1;
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles, %0d errors so far",
                 TIMEOUT_CYCLES, errors);
        $display("Something failed");
        $finish;
    end

    initial begin
        int addr;
        lfsr_state = 16'd21;
        reset      = 1'b1;
        in_data    = 8'h00;
        in_valid   = 1'b0;

        repeat (4) begin
            next_cycle();
            check_quiet_outputs(1'b0);
        end
        reset = 1'b0;
        next_cycle();
        check_quiet_outputs(1'b1);

        // whole framebuffer with random colours
        for (int a = 0; a < led_panel_pkg::PANEL_WIDTH * led_panel_pkg::PANEL_HEIGHT; a++) begin
            write_pixel(a, led_panel_pkg::pixel_t'(random_bits(6)));
        end
        check_frames(2);

        write_rgb_enable(3'b101);  // green off
        check_frames(1);

        write_plane_enable(2'b01);  // plane 1 off
        check_frames(1);

        // unknown opcode must be dropped without shifting the message framing
        write_rgb_enable('1);
        write_plane_enable('1);
        send_byte(8'hA5);
        addr = 37;
        write_pixel(addr, ~shadow_fb[addr]);
        check_frames(1);

        if (rows_checked == 0) begin
            errors++;
            $display("no rows were compared");
        end
        $display("checks done: %0d errors over %0d compared rows", errors, rows_checked);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== hdl/led_panel_top.sv ====
`timescale 1ns/10ps

module led_panel_top (
    input  logic                clk_in,
    input  logic                reset,
    input  logic [7:0]          in_data,
    input  logic                in_valid,
    output logic                in_ready,
    output led_panel_pkg::rgb_t rgb_top,
    output led_panel_pkg::rgb_t rgb_bottom,
    output logic                clk_pixel,
    output logic                row_latch,
    output logic                output_enable,
    output led_panel_pkg::row_t row_address
);

    led_panel_pkg::pixel_write_t  pix_wr;
    led_panel_pkg::config_write_t cfg_wr;
    led_panel_pkg::rgb_t          rgb_enable;
    led_panel_pkg::plane_mask_t   plane_enable;
    led_panel_pkg::pix_addr_t     rd_addr_top;
    led_panel_pkg::pix_addr_t     rd_addr_bottom;
    led_panel_pkg::pixel_t        rd_data_top;
    led_panel_pkg::pixel_t        rd_data_bottom;
    logic                         load_valid;
    led_panel_pkg::col_t          load_col;
    led_panel_pkg::row_t          load_row;
    led_panel_pkg::plane_t        load_plane;

    command_parser ctrl (
        .clk_in(clk_in), .reset(reset),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .pix_wr(pix_wr), .cfg_wr(cfg_wr)
    );

    display_config cfg (
        .clk_in(clk_in), .reset(reset), .cfg_wr(cfg_wr),
        .rgb_enable(rgb_enable), .plane_enable(plane_enable)
    );

    frame_memory fb (
        .clk_in(clk_in), .wr(pix_wr),
        .rd_addr_top(rd_addr_top), .rd_addr_bottom(rd_addr_bottom),
        .rd_data_top(rd_data_top), .rd_data_bottom(rd_data_bottom)
    );

    matrix_scan matscan (
        .clk_in(clk_in), .reset(reset),
        .load_valid(load_valid), .load_col(load_col),
        .load_row(load_row), .load_plane(load_plane),
        .row_latch(row_latch), .output_enable(output_enable),
        .row_address(row_address)
    );

    pixel_fetch fb_f (
        .clk_in(clk_in), .reset(reset),
        .load_valid(load_valid), .load_col(load_col),
        .load_row(load_row), .load_plane(load_plane),
        .rgb_enable(rgb_enable), .plane_enable(plane_enable),
        .rd_addr_top(rd_addr_top), .rd_addr_bottom(rd_addr_bottom),
        .rd_data_top(rd_data_top), .rd_data_bottom(rd_data_bottom),
        .rgb_top(rgb_top), .rgb_bottom(rgb_bottom), .clk_pixel(clk_pixel)
    );

endmodule

// ==== hdl/pixel_fetch.sv ====
`timescale 1ns/10ps

module pixel_fetch (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       load_valid,
    input  led_panel_pkg::col_t        load_col,
    input  led_panel_pkg::row_t        load_row,
    input  led_panel_pkg::plane_t      load_plane,
    input  led_panel_pkg::rgb_t        rgb_enable,
    input  led_panel_pkg::plane_mask_t plane_enable,
    output led_panel_pkg::pix_addr_t   rd_addr_top,
    output led_panel_pkg::pix_addr_t   rd_addr_bottom,
    input  led_panel_pkg::pixel_t      rd_data_top,
    input  led_panel_pkg::pixel_t      rd_data_bottom,
    output led_panel_pkg::rgb_t        rgb_top,
    output led_panel_pkg::rgb_t        rgb_bottom,
    output logic                       clk_pixel
);

    logic                  rd_valid;  // travels with the memory read
    led_panel_pkg::plane_t rd_plane;
    led_panel_pkg::rgb_t   mask;

    // bit `plane` of each 2-bit channel
    function automatic led_panel_pkg::rgb_t plane_bits(led_panel_pkg::pixel_t pix,
                                                       led_panel_pkg::plane_t p);
        led_panel_pkg::rgb_t bits;
        for (int c = 0; c < 3; c++) begin
            bits[c] = pix[c * led_panel_pkg::PLANES + int'(p)];
        end
        return bits;
    endfunction

    assign rd_addr_top    = led_panel_pkg::pix_addr_t'({load_row, load_col});
    assign rd_addr_bottom = rd_addr_top + led_panel_pkg::pix_addr_t'(
                                led_panel_pkg::HALF_HEIGHT * led_panel_pkg::PANEL_WIDTH);

    assign mask = rgb_enable & {3{plane_enable[rd_plane]}};

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rd_valid  <= 1'b0;
            clk_pixel <= 1'b0;
        end else begin
            rd_valid  <= load_valid;
            clk_pixel <= rd_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        rd_plane <= load_plane;
        if (rd_valid) begin
            rgb_top    <= plane_bits(rd_data_top, rd_plane) & mask;
            rgb_bottom <= plane_bits(rd_data_bottom, rd_plane) & mask;
        end
    end

endmodule

// ==== hdl/matrix_scan.sv ====
`timescale 1ns/10ps

module matrix_scan (
    input  logic                  clk_in,
    input  logic                  reset,
    output logic                  load_valid,
    output led_panel_pkg::col_t   load_col,
    output led_panel_pkg::row_t   load_row,
    output led_panel_pkg::plane_t load_plane,
    output logic                  row_latch,
    output logic                  output_enable,
    output led_panel_pkg::row_t   row_address
);

    led_panel_pkg::scan_state_t state;
    led_panel_pkg::col_t        col_cnt;
    led_panel_pkg::drain_cnt_t  drain_cnt;
    led_panel_pkg::disp_cnt_t   disp_cnt;
    led_panel_pkg::disp_cnt_t   disp_last;
    led_panel_pkg::row_t        row;
    led_panel_pkg::plane_t      plane;

    // plane p stays lit DISPLAY_UNIT << p cycles
    always_comb begin
        disp_last = led_panel_pkg::disp_cnt_t'((led_panel_pkg::DISPLAY_UNIT << plane) - 1);
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state       <= led_panel_pkg::SHIFT;
            col_cnt     <= '0;
            drain_cnt   <= '0;
            disp_cnt    <= '0;
            row         <= '0;
            plane       <= '0;
            row_address <= '0;
        end else begin
            case (state)
                led_panel_pkg::SHIFT: begin
                    col_cnt <= col_cnt + led_panel_pkg::col_t'(1);
                    if (col_cnt == led_panel_pkg::col_t'(led_panel_pkg::PANEL_WIDTH - 1)) begin
                        col_cnt   <= '0;
                        drain_cnt <= '0;
                        state     <= led_panel_pkg::DRAIN;
                    end
                end
                // wait for the last columns still in the fetch pipe
                led_panel_pkg::DRAIN: begin
                    drain_cnt <= drain_cnt + led_panel_pkg::drain_cnt_t'(1);
                    if (drain_cnt ==
                        led_panel_pkg::drain_cnt_t'(led_panel_pkg::FETCH_LATENCY - 1)) begin
                        row_address <= row;  // visible during the latch cycle
                        state       <= led_panel_pkg::LATCH;
                    end
                end
                led_panel_pkg::LATCH: begin
                    disp_cnt <= '0;
                    state    <= led_panel_pkg::DISPLAY;
                end
                default: begin
                    disp_cnt <= disp_cnt + led_panel_pkg::disp_cnt_t'(1);
                    if (disp_cnt == disp_last) begin
                        state <= led_panel_pkg::SHIFT;
                        if (plane == led_panel_pkg::plane_t'(led_panel_pkg::PLANES - 1)) begin
                            plane <= '0;
                            row   <= row + led_panel_pkg::row_t'(1);  // wraps after row 3
                        end else begin
                            plane <= plane + led_panel_pkg::plane_t'(1);
                        end
                    end
                end
            endcase
        end
    end

    assign load_valid    = (state == led_panel_pkg::SHIFT);  // one column per cycle
    assign load_col      = col_cnt;
    assign load_row      = row;
    assign load_plane    = plane;
    assign row_latch     = (state == led_panel_pkg::LATCH);
    assign output_enable = (state == led_panel_pkg::DISPLAY);

endmodule

// ==== hdl/frame_memory.sv ====
`timescale 1ns/10ps

module frame_memory (
    input  logic                        clk_in,
    input  led_panel_pkg::pixel_write_t wr,
    input  led_panel_pkg::pix_addr_t    rd_addr_top,
    input  led_panel_pkg::pix_addr_t    rd_addr_bottom,
    output led_panel_pkg::pixel_t       rd_data_top,
    output led_panel_pkg::pixel_t       rd_data_bottom
);

    localparam int DEPTH = led_panel_pkg::PANEL_WIDTH * led_panel_pkg::PANEL_HEIGHT;

    led_panel_pkg::pixel_t mem [DEPTH];

    // blank panel at power-up
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (wr.valid) begin
            mem[wr.addr] <= wr.pixel;  // port a
        end
    end

    // port b, one read per half-panel
    always_ff @(posedge clk_in) begin
        rd_data_top    <= mem[rd_addr_top];
        rd_data_bottom <= mem[rd_addr_bottom];
    end

endmodule

// ==== hdl/display_config.sv ====
`timescale 1ns/10ps

module display_config (
    input  logic                         clk_in,
    input  logic                         reset,
    input  led_panel_pkg::config_write_t cfg_wr,
    output led_panel_pkg::rgb_t          rgb_enable,
    output led_panel_pkg::plane_mask_t   plane_enable
);

    // per-channel colour enable
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable <= '1;  // all channels on
        end else if (cfg_wr.valid_rgb) begin
            rgb_enable <= cfg_wr.rgb;
        end
    end

    // per-plane brightness enable
    always_ff @(posedge clk_in) begin
        if (reset) begin
            plane_enable <= '1;
        end else if (cfg_wr.valid_plane) begin
            plane_enable <= cfg_wr.plane;
        end
    end

endmodule

// ==== hdl/command_parser.sv ====
`timescale 1ns/10ps

module command_parser (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic [7:0]                   in_data,
    input  logic                         in_valid,
    output logic                         in_ready,
    output led_panel_pkg::pixel_write_t  pix_wr,
    output led_panel_pkg::config_write_t cfg_wr
);

    // which byte of a message comes next
    typedef enum logic [1:0] {
        EXPECT_OPCODE,
        EXPECT_ADDR,
        EXPECT_COLOUR,
        EXPECT_VALUE
    } parse_state_t;

    parse_state_t              state;
    led_panel_pkg::opcode_t    opcode_q;
    led_panel_pkg::pix_addr_t  addr_q;
    logic                      accept;

    logic                      pix_valid;
    led_panel_pkg::pix_addr_t  pix_addr;
    led_panel_pkg::pixel_t     pix_data;
    logic                      rgb_valid;
    logic                      plane_valid;
    led_panel_pkg::rgb_t       rgb_value;
    led_panel_pkg::plane_mask_t plane_value;

    assign accept = in_valid & in_ready;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state       <= EXPECT_OPCODE;
            in_ready    <= 1'b0;
            pix_valid   <= 1'b0;
            rgb_valid   <= 1'b0;
            plane_valid <= 1'b0;
        end else begin
            in_ready    <= 1'b1;  // every byte finishes in one cycle
            pix_valid   <= 1'b0;
            rgb_valid   <= 1'b0;
            plane_valid <= 1'b0;
            if (accept) begin
                case (state)
                    EXPECT_OPCODE: begin
                        case (led_panel_pkg::opcode_t'(in_data))
                            led_panel_pkg::OP_PIXEL:        state <= EXPECT_ADDR;
                            led_panel_pkg::OP_RGB_ENABLE:   state <= EXPECT_VALUE;
                            led_panel_pkg::OP_PLANE_ENABLE: state <= EXPECT_VALUE;
                            default:                        state <= EXPECT_OPCODE; // dropped
                        endcase
                    end
                    EXPECT_ADDR:   state <= EXPECT_COLOUR;
                    EXPECT_COLOUR: begin
                        pix_valid <= 1'b1;
                        state     <= EXPECT_OPCODE;
                    end
                    default: begin
                        rgb_valid   <= (opcode_q == led_panel_pkg::OP_RGB_ENABLE);
                        plane_valid <= (opcode_q == led_panel_pkg::OP_PLANE_ENABLE);
                        state       <= EXPECT_OPCODE;
                    end
                endcase
            end
        end
    end

    // held message fields and write payloads
    always_ff @(posedge clk_in) begin
        if (accept) begin
            case (state)
                EXPECT_OPCODE: opcode_q <= led_panel_pkg::opcode_t'(in_data);
                EXPECT_ADDR:   addr_q   <= in_data[led_panel_pkg::ADDR_BITS-1:0];
                EXPECT_COLOUR: begin
                    pix_addr <= addr_q;
                    pix_data <= in_data[$bits(led_panel_pkg::pixel_t)-1:0];
                end
                default: begin
                    rgb_value   <= in_data[$bits(led_panel_pkg::rgb_t)-1:0];
                    plane_value <= in_data[led_panel_pkg::PLANES-1:0];
                end
            endcase
        end
    end

    assign pix_wr = '{valid: pix_valid, addr: pix_addr, pixel: pix_data};
    assign cfg_wr = '{valid_rgb: rgb_valid, valid_plane: plane_valid,
                      rgb: rgb_value, plane: plane_value};

endmodule

// ==== hdl/led_panel_pkg.sv ====
package led_panel_pkg;

    // panel geometry
    localparam int PANEL_WIDTH  = 16;
    localparam int PANEL_HEIGHT = 8;
    localparam int HALF_HEIGHT  = PANEL_HEIGHT / 2;
    localparam int COL_BITS     = 4;
    localparam int ROW_BITS     = 2;  // row within one half-panel
    localparam int ADDR_BITS    = 7;  // full row * 16 + column

    // binary-coded modulation
    localparam int PLANES        = 2;
    localparam int DISPLAY_UNIT  = 8;  // oe cycles of plane 0
    localparam int FETCH_LATENCY = 2;  // load request to clk_pixel

    // scan counter widths
    localparam int DRAIN_BITS = $clog2(FETCH_LATENCY);
    localparam int DISP_BITS  = $clog2(DISPLAY_UNIT) + PLANES - 1;

    typedef logic [COL_BITS-1:0]   col_t;
    typedef logic [ROW_BITS-1:0]   row_t;
    typedef logic [ADDR_BITS-1:0]  pix_addr_t;
    typedef logic [0:0]            plane_t;
    typedef logic [3*PLANES-1:0]   pixel_t;       // r 5:4, g 3:2, b 1:0
    typedef logic [2:0]            rgb_t;         // red is bit 2
    typedef logic [PLANES-1:0]     plane_mask_t;
    typedef logic [DRAIN_BITS-1:0] drain_cnt_t;
    typedef logic [DISP_BITS-1:0]  disp_cnt_t;

    typedef enum logic [7:0] {
        OP_PIXEL        = 8'h01,  // then address, colour
        OP_RGB_ENABLE   = 8'h02,  // then one value byte
        OP_PLANE_ENABLE = 8'h03   // then one value byte
    } opcode_t;

    typedef enum logic [1:0] {SHIFT, DRAIN, LATCH, DISPLAY} scan_state_t;

    typedef struct packed {
        logic      valid;
        pix_addr_t addr;
        pixel_t    pixel;
    } pixel_write_t;

    typedef struct packed {
        logic        valid_rgb;
        logic        valid_plane;
        rgb_t        rgb;
        plane_mask_t plane;
    } config_write_t;

endpackage
